// ==== eth_macros.svh ====
`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// Own station
`define MY_MAC 48'h00_AA_BB_CC_DD_EE
`define MY_IP 32'h0A_05_05_05

// Fixed peer for outgoing UDP, no ARP cache
`define DEST_MAC 48'h30_85_A9_13_05_32
`define DEST_IP 32'h0A_05_05_01

// UDP ports
`define MY_UDP_PORT 16'd50000
`define DEST_UDP_PORT 16'd50001

// Largest payload that fits a 1500 byte IP packet
`define UDP_MAX_PAYLOAD 16'd1472

`endif

// ==== eth_pkg.sv ====
`default_nettype none

package eth_pkg;

	typedef logic [7:0] octet_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	// Requester of an ARP request
	typedef struct packed {
		mac_addr_t mac;
		ip_addr_t ip;
	} arp_peer_t;

	// One frame source toward the transmit arbiter
	typedef struct packed {
		octet_t data;
		logic valid;
	} tx_byte_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_eth_hdr,
		rx_arp_body,
		rx_ip_hdr,
		rx_udp_hdr,
		rx_payload,
		rx_drain
	} rx_state_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_checksum,
		tx_header,
		tx_payload
	} tx_state_t;

	typedef enum logic {
		arp_idle,
		arp_send
	} arp_state_t;

endpackage

`default_nettype wire

// ==== eth_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module eth_rx_parser (
	input  wire logic              eth_clk,
	input  wire logic              rst,
	input  wire eth_pkg::octet_t   eth_rx_data,
	input  wire logic              eth_rx_data_valid,
	input  wire logic              eth_rx_frame_good,
	input  wire logic              eth_rx_frame_bad,
	output eth_pkg::octet_t        udp_rx,
	output logic                   udp_rx_dv,
	output logic                   arp_req,
	output eth_pkg::arp_peer_t     arp_peer
);
	import eth_pkg::*;

	rx_state_t state;
	logic [10:0] idx;
	logic [39:0] shreg;
	logic [15:0] remain;
	mac_addr_t cur48;
	ip_addr_t cur32;
	logic [15:0] cur16;

	// Last bytes of the frame including the current one
	assign cur48 = {shreg, eth_rx_data};
	assign cur32 = cur48[31:0];
	assign cur16 = cur48[15:0];

	always_ff @(posedge eth_clk) begin
		if (rst) begin
			state <= rx_idle;
			idx <= '0;
			remain <= '0;
			arp_req <= 1'b0;
			udp_rx_dv <= 1'b0;
		end else begin
			arp_req <= 1'b0;
			udp_rx_dv <= 1'b0;
			if (eth_rx_frame_good || eth_rx_frame_bad) begin
				state <= rx_idle;
				idx <= '0;
			end else if (eth_rx_data_valid) begin
				idx <= idx + 11'd1;
				case (state)
					rx_idle: state <= rx_eth_hdr;
					rx_eth_hdr: begin
						if (idx == 11'd5 && cur48 != `MY_MAC && cur48 != 48'hFFFF_FFFF_FFFF)
							state <= rx_drain;
						if (idx == 11'd13) begin
							if (cur16 == 16'h0806)
								state <= rx_arp_body;
							else if (cur16 == 16'h0800)
								state <= rx_ip_hdr;
							else
								state <= rx_drain;
						end
					end
					rx_arp_body: begin
						// Opcode 1 is a request
						if (idx == 11'd21 && cur16 != 16'h0001)
							state <= rx_drain;
						if (idx == 11'd41) begin
							arp_req <= (cur32 == `MY_IP);
							state <= rx_drain;
						end
					end
					rx_ip_hdr: begin
						if (idx == 11'd14 && eth_rx_data != 8'h45)
							state <= rx_drain;
						if (idx == 11'd23 && eth_rx_data != 8'd17)
							state <= rx_drain;
						if (idx == 11'd33)
							state <= (cur32 == `MY_IP) ? rx_udp_hdr : rx_drain;
					end
					rx_udp_hdr: begin
						if (idx == 11'd37 && cur16 != `MY_UDP_PORT)
							state <= rx_drain;
						if (idx == 11'd39) begin
							remain <= cur16 - 16'd8;
							// No payload at all
							if (cur16 < 16'd9)
								state <= rx_drain;
						end
						if (idx == 11'd41)
							state <= rx_payload;
					end
					rx_payload: begin
						udp_rx_dv <= 1'b1;
						remain <= remain - 16'd1;
						// Anything past the UDP length is pad
						if (remain == 16'd1)
							state <= rx_drain;
					end
					rx_drain: state <= rx_drain;
					default: state <= rx_drain;
				endcase
			end
		end
	end

	always_ff @(posedge eth_clk) begin
		if (eth_rx_data_valid) begin
			shreg <= cur48[39:0];
			udp_rx <= eth_rx_data;
			if (state == rx_arp_body && idx == 11'd27)
				arp_peer.mac <= cur48;
			if (state == rx_arp_body && idx == 11'd31)
				arp_peer.ip <= cur32;
		end
	end

endmodule

`default_nettype wire

// ==== arp_responder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module arp_responder (
	input  wire logic               eth_clk,
	input  wire logic               rst,
	input  wire logic               arp_req,
	input  wire eth_pkg::arp_peer_t arp_peer,
	input  wire logic               arp_ack,
	output eth_pkg::tx_byte_t       arp_tx
);
	import eth_pkg::*;

	arp_state_t state;
	arp_peer_t peer;
	logic [5:0] idx;
	logic acked;
	logic out_valid;
	octet_t out_data;
	logic [335:0] reply;

	// Ethernet header then ARP reply body
	assign reply = {
		peer.mac, `MY_MAC, 16'h0806,
		16'h0001, 16'h0800, 8'd6, 8'd4, 16'h0002,
		`MY_MAC, `MY_IP, peer.mac, peer.ip
	};

	assign arp_tx = '{data: out_data, valid: out_valid};

	always_ff @(posedge eth_clk) begin
		if (rst) begin
			state <= arp_idle;
			idx <= '0;
			acked <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			case (state)
				arp_idle: begin
					if (arp_req) begin
						state <= arp_send;
						idx <= '0;
						acked <= 1'b0;
					end
				end
				arp_send: begin
					if (!out_valid && !acked) begin
						// First byte waits here for ack
						out_valid <= 1'b1;
						idx <= 6'd1;
					end else if (arp_ack || acked) begin
						acked <= 1'b1;
						if (idx == 6'd42) begin
							out_valid <= 1'b0;
							state <= arp_idle;
						end else begin
							idx <= idx + 6'd1;
						end
					end
				end
				default: state <= arp_idle;
			endcase
		end
	end

	always_ff @(posedge eth_clk) begin
		if (state == arp_idle && arp_req)
			peer <= arp_peer;
		// Byte 0 is loaded once and then held until ack
		if (state == arp_send && idx != 6'd42 && (!out_valid || arp_ack || acked))
			out_data <= reply[8 * (41 - idx) +: 8];
	end

endmodule

`default_nettype wire

// ==== udp_tx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module udp_tx_framer (
	input  wire logic            eth_clk,
	input  wire logic            rst,
	input  wire logic [15:0]     udp_tx_pending_data,
	input  wire eth_pkg::octet_t udp_tx,
	input  wire logic            udp_ack,
	output logic                 udp_tx_rden,
	output eth_pkg::tx_byte_t    udp_tx_byte
);
	import eth_pkg::*;

	localparam ip_addr_t src_ip = `MY_IP;
	localparam ip_addr_t dst_ip = `DEST_IP;
	// Header words that never change, total length is added at run time
	localparam logic [19:0] const_sum = 20'h04500 + 20'h04011
		+ {4'd0, src_ip[31:16]} + {4'd0, src_ip[15:0]}
		+ {4'd0, dst_ip[31:16]} + {4'd0, dst_ip[15:0]};

	tx_state_t state;
	logic [1:0] step;
	logic [15:0] len;
	logic [15:0] idx;
	logic [19:0] sum;
	logic [15:0] csum;
	logic acked;
	logic out_valid;
	octet_t out_data;
	logic streaming;
	logic rden_due;
	logic [15:0] tot_len;
	logic [15:0] udp_len;
	logic [15:0] frame_end;
	logic [335:0] hdr;

	assign tot_len = len + 16'd28;
	assign udp_len = len + 16'd8;
	assign frame_end = len + 16'd42;
	assign streaming = udp_ack || acked;
	// A payload byte is requested two bytes before it goes out
	assign rden_due = (idx >= 16'd40) && (idx < len + 16'd40);

	assign hdr = {
		`DEST_MAC, `MY_MAC, 16'h0800,
		8'h45, 8'h00, tot_len, 16'h0000, 16'h0000, 8'd64, 8'd17, csum,
		src_ip, dst_ip,
		`MY_UDP_PORT, `DEST_UDP_PORT, udp_len, 16'h0000
	};

	assign udp_tx_byte = '{data: out_data, valid: out_valid};

	always_ff @(posedge eth_clk) begin
		if (rst) begin
			state <= tx_idle;
			step <= '0;
			idx <= '0;
			acked <= 1'b0;
			out_valid <= 1'b0;
			udp_tx_rden <= 1'b0;
		end else begin
			udp_tx_rden <= 1'b0;
			case (state)
				tx_idle: begin
					if (udp_tx_pending_data != 16'd0) begin
						state <= tx_checksum;
						step <= '0;
					end
				end
				tx_checksum: begin
					step <= step + 2'd1;
					if (step == 2'd2) begin
						state <= tx_header;
						out_valid <= 1'b1;
						idx <= 16'd1;
						acked <= 1'b0;
					end
				end
				tx_header: begin
					if (streaming) begin
						acked <= 1'b1;
						idx <= idx + 16'd1;
						udp_tx_rden <= rden_due;
						if (idx == 16'd41)
							state <= tx_payload;
					end
				end
				tx_payload: begin
					if (idx == frame_end) begin
						out_valid <= 1'b0;
						state <= tx_idle;
					end else begin
						idx <= idx + 16'd1;
						udp_tx_rden <= rden_due;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	always_ff @(posedge eth_clk) begin
		case (state)
			tx_idle: begin
				if (udp_tx_pending_data > `UDP_MAX_PAYLOAD)
					len <= `UDP_MAX_PAYLOAD;
				else
					len <= udp_tx_pending_data;
			end
			tx_checksum: begin
				case (step)
					2'd0: sum <= const_sum + {4'd0, tot_len};
					2'd1: sum <= {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
					default: begin
						// Second fold cannot carry again
						csum <= ~(sum[15:0] + {12'd0, sum[19:16]});
						out_data <= hdr[335:328];
					end
				endcase
			end
			tx_header: begin
				if (streaming)
					out_data <= hdr[8 * (41 - idx[5:0]) +: 8];
			end
			tx_payload: begin
				if (idx != frame_end)
					out_data <= udp_tx;
			end
			default: out_data <= out_data;
		endcase
	end

endmodule

`default_nettype wire

// ==== tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
	input  wire logic              eth_clk,
	input  wire logic              rst,
	input  wire eth_pkg::tx_byte_t arp_tx,
	input  wire eth_pkg::tx_byte_t udp_tx_byte,
	input  wire logic              eth_tx_ack,
	output eth_pkg::octet_t        eth_tx_data,
	output logic                   eth_tx_data_en,
	output logic                   arp_ack,
	output logic                   udp_ack
);
	import eth_pkg::*;

	logic busy;
	logic sel_udp;
	tx_byte_t granted;

	assign granted = sel_udp ? udp_tx_byte : arp_tx;

	always_ff @(posedge eth_clk) begin
		if (rst) begin
			busy <= 1'b0;
			sel_udp <= 1'b0;
		end else if (!busy) begin
			// ARP has priority between frames
			if (arp_tx.valid) begin
				busy <= 1'b1;
				sel_udp <= 1'b0;
			end else if (udp_tx_byte.valid) begin
				busy <= 1'b1;
				sel_udp <= 1'b1;
			end
		end else if (!granted.valid) begin
			busy <= 1'b0;
		end
	end

	assign eth_tx_data = busy ? granted.data : 8'h00;
	assign eth_tx_data_en = busy && granted.valid;
	assign arp_ack = busy && !sel_udp && eth_tx_ack;
	assign udp_ack = busy && sel_udp && eth_tx_ack;

endmodule

`default_nettype wire

// ==== ip_minimal.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_minimal (
	input  wire logic            eth_clk,
	input  wire logic            rst,
	input  wire eth_pkg::octet_t eth_rx_data,
	input  wire logic            eth_rx_data_valid,
	input  wire logic            eth_rx_frame_good,
	input  wire logic            eth_rx_frame_bad,
	output wire eth_pkg::octet_t eth_tx_data,
	output wire logic            eth_tx_data_en,
	input  wire logic            eth_tx_ack,
	output wire eth_pkg::octet_t udp_rx,
	output wire logic            udp_rx_dv,
	input  wire logic [15:0]     udp_tx_pending_data,
	input  wire eth_pkg::octet_t udp_tx,
	output wire logic            udp_tx_rden
);
	import eth_pkg::*;

	wire logic arp_req;
	wire arp_peer_t arp_peer;
	wire tx_byte_t arp_tx;
	wire tx_byte_t udp_tx_byte;
	wire logic arp_ack;
	wire logic udp_ack;

	eth_rx_parser parser0 (
		.eth_clk(eth_clk),
		.rst(rst),
		.eth_rx_data(eth_rx_data),
		.eth_rx_data_valid(eth_rx_data_valid),
		.eth_rx_frame_good(eth_rx_frame_good),
		.eth_rx_frame_bad(eth_rx_frame_bad),
		.udp_rx(udp_rx),
		.udp_rx_dv(udp_rx_dv),
		.arp_req(arp_req),
		.arp_peer(arp_peer)
	);

	arp_responder arp0 (
		.eth_clk(eth_clk),
		.rst(rst),
		.arp_req(arp_req),
		.arp_peer(arp_peer),
		.arp_ack(arp_ack),
		.arp_tx(arp_tx)
	);

	udp_tx_framer framer0 (
		.eth_clk(eth_clk),
		.rst(rst),
		.udp_tx_pending_data(udp_tx_pending_data),
		.udp_tx(udp_tx),
		.udp_ack(udp_ack),
		.udp_tx_rden(udp_tx_rden),
		.udp_tx_byte(udp_tx_byte)
	);

	tx_arbiter arb0 (
		.eth_clk(eth_clk),
		.rst(rst),
		.arp_tx(arp_tx),
		.udp_tx_byte(udp_tx_byte),
		.eth_tx_ack(eth_tx_ack),
		.eth_tx_data(eth_tx_data),
		.eth_tx_data_en(eth_tx_data_en),
		.arp_ack(arp_ack),
		.udp_ack(udp_ack)
	);

endmodule

`default_nettype wire

// ==== tb_ip_minimal.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module tb_ip_minimal;
	import eth_pkg::*;

	localparam int NUM_ROWS = 8;

	typedef enum logic [2:0] {
		k_arp,
		k_udp,
		k_bad_port,
		k_bad_ip,
		k_not_ip
	} frame_kind_t;

	// One test row with received frame kind, payload length and UDP send flag
	typedef struct packed {
		frame_kind_t kind;
		logic [15:0] len;
		logic send;
	} row_t;

	logic eth_clk;
	logic rst;
	octet_t eth_rx_data;
	logic eth_rx_data_valid;
	logic eth_rx_frame_good;
	logic eth_rx_frame_bad;
	octet_t eth_tx_data;
	logic eth_tx_data_en;
	logic eth_tx_ack;
	octet_t udp_rx;
	logic udp_rx_dv;
	logic [15:0] udp_tx_pending_data;
	octet_t udp_tx;
	logic udp_tx_rden;

	row_t rows [NUM_ROWS];
	logic [15:0] stim_lfsr;
	logic [15:0] ack_lfsr;
	logic [15:0] src_lfsr;
	octet_t rx_frame [$];
	octet_t exp_rx [$];
	octet_t rx_got [$];
	octet_t exp_tx [$];
	bit exp_kind [$];
	octet_t got_tx [$];
	int got_len [$];
	octet_t src_bytes [$];
	int rden_count;

	ip_minimal dut0 (
		.eth_clk(eth_clk),
		.rst(rst),
		.eth_rx_data(eth_rx_data),
		.eth_rx_data_valid(eth_rx_data_valid),
		.eth_rx_frame_good(eth_rx_frame_good),
		.eth_rx_frame_bad(eth_rx_frame_bad),
		.eth_tx_data(eth_tx_data),
		.eth_tx_data_en(eth_tx_data_en),
		.eth_tx_ack(eth_tx_ack),
		.udp_rx(udp_rx),
		.udp_rx_dv(udp_rx_dv),
		.udp_tx_pending_data(udp_tx_pending_data),
		.udp_tx(udp_tx),
		.udp_tx_rden(udp_tx_rden)
	);

	initial begin
		eth_clk = 1'b0;
		forever #50 eth_clk = ~eth_clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [7:0] lfsr_take(inout logic [15:0] st, input int n);
		logic [7:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[6:0], st[0]};
			st = st[0] ? ((st >> 1) ^ 16'hB400) : (st >> 1);
		end
		return v;
	endfunction

	// IPv4 header with ID 0, TTL 64, UDP, checksum filled in
	function automatic logic [159:0] ip_header(input logic [15:0] len);
		logic [159:0] h;
		logic [31:0] s;
		int i;
		h = {8'h45, 8'h00, len + 16'd28, 16'h0000, 16'h0000, 8'd64, 8'd17, 16'h0000,
			`MY_IP, `DEST_IP};
		s = '0;
		for (i = 0; i < 10; i++)
			s = s + {16'd0, h[16 * i +: 16]};
		while (s[31:16] != 16'd0)
			s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		h[79:64] = ~s[15:0];
		return h;
	endfunction

	task automatic check_octet(input string what, input octet_t got, input octet_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_peer(input string what, input arp_peer_t got, input arp_peer_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic rx_put(input logic [47:0] v, input int n);
		int i;
		for (i = n - 1; i >= 0; i--)
			rx_frame.push_back(v[8 * i +: 8]);
	endtask

	task automatic exp_put(input logic [47:0] v, input int n);
		int i;
		for (i = n - 1; i >= 0; i--)
			exp_tx.push_back(v[8 * i +: 8]);
	endtask

	task automatic build_request(input row_t row, input arp_peer_t peer);
		logic [15:0] etype;
		logic [31:0] dip;
		logic [15:0] port;
		octet_t b;
		int i;
		if (row.kind == k_arp) begin
			rx_put(48'hFFFF_FFFF_FFFF, 6);
			rx_put(peer.mac, 6);
			rx_put(48'h0806_0001_0800, 6);
			rx_put(48'h0604_0001, 4);
			rx_put(peer.mac, 6);
			rx_put(peer.ip, 4);
			rx_put(48'h0, 6);
			rx_put(`MY_IP, 4);
		end else begin
			etype = (row.kind == k_not_ip) ? 16'h86DD : 16'h0800;
			dip = (row.kind == k_bad_ip) ? (`MY_IP ^ 32'h1) : `MY_IP;
			port = (row.kind == k_bad_port) ? (`MY_UDP_PORT + 16'd1) : `MY_UDP_PORT;
			rx_put(`MY_MAC, 6);
			rx_put(peer.mac, 6);
			rx_put(etype, 2);
			rx_put(16'h4500, 2);
			rx_put(row.len + 16'd28, 2);
			rx_put(32'h0, 4);
			rx_put(16'h4011, 2);
			rx_put(16'h0, 2);
			rx_put(peer.ip, 4);
			rx_put(dip, 4);
			rx_put(16'd1234, 2);
			rx_put(port, 2);
			rx_put(row.len + 16'd8, 2);
			rx_put(16'h0, 2);
			for (i = 0; i < int'(row.len); i++) begin
				b = lfsr_take(stim_lfsr, 8);
				rx_frame.push_back(b);
				if (row.kind == k_udp)
					exp_rx.push_back(b);
			end
		end
		// Pad up to the minimum frame size
		while (rx_frame.size() < 60)
			rx_frame.push_back(8'hA5);
	endtask

	task automatic build_reply(input arp_peer_t peer);
		exp_put(peer.mac, 6);
		exp_put(`MY_MAC, 6);
		exp_put(48'h0806_0001_0800, 6);
		exp_put(48'h0604_0002, 4);
		exp_put(`MY_MAC, 6);
		exp_put(`MY_IP, 4);
		exp_put(peer.mac, 6);
		exp_put(peer.ip, 4);
		exp_kind.push_back(1'b0);
	endtask

	task automatic build_udp_header(input logic [15:0] len);
		logic [159:0] h;
		int i;
		exp_put(`DEST_MAC, 6);
		exp_put(`MY_MAC, 6);
		exp_put(16'h0800, 2);
		h = ip_header(len);
		for (i = 0; i < 20; i++)
			exp_tx.push_back(h[159 - 8 * i -: 8]);
		exp_put(`MY_UDP_PORT, 2);
		exp_put(`DEST_UDP_PORT, 2);
		exp_put(len + 16'd8, 2);
		exp_put(16'h0, 2);
		exp_kind.push_back(1'b1);
	endtask

	// Send starts with byte 40 so that the framer's valid rises with the ARP reply's
	task automatic apply_frame(input row_t row);
		int i;
		for (i = 0; i < rx_frame.size(); i++) begin
			@(negedge eth_clk);
			eth_rx_data = rx_frame[i];
			eth_rx_data_valid = 1'b1;
			udp_tx_pending_data = (row.send && i == 40) ? row.len : 16'd0;
		end
		@(negedge eth_clk);
		eth_rx_data_valid = 1'b0;
		udp_tx_pending_data = 16'd0;
		eth_rx_frame_good = 1'b1;
		@(negedge eth_clk);
		eth_rx_frame_good = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (got_len.size() < n) begin
			@(negedge eth_clk);
			cycles++;
			if (cycles > 5000)
				abort_run("transmit frames did not arrive in time");
		end
	endtask

	task automatic compare_tx(input logic [15:0] len, input arp_peer_t peer);
		arp_peer_t rec;
		int pos;
		int f;
		int b;
		pos = 0;
		check_count("transmitted frames", got_len.size(), exp_kind.size());
		for (f = 0; f < exp_kind.size(); f++) begin
			check_count("frame length", got_len[f], exp_kind[f] ? 42 + int'(len) : 42);
			if (!exp_kind[f]) begin
				rec = '0;
				for (b = 0; b < 10; b++)
					rec = {rec[71:0], got_tx[pos + 32 + b]};
				check_peer("requester in reply", rec, peer);
			end
			for (b = 0; b < 42; b++)
				check_octet($sformatf("frame %0d header byte %0d", f, b),
					got_tx[pos + b], exp_tx[42 * f + b]);
			if (exp_kind[f]) begin
				check_count("udp_tx_rden pulses", rden_count, int'(len));
				for (b = 0; b < int'(len); b++)
					check_octet($sformatf("sent payload byte %0d", b),
						got_tx[pos + 42 + b], src_bytes[b]);
			end
			pos = pos + got_len[f];
		end
	endtask

	// MAC model that counts the held first byte at ack
	initial begin : mac_model
		int delay;
		int n;
		eth_tx_ack = 1'b0;
		forever begin
			@(negedge eth_clk);
			if (eth_tx_data_en === 1'b1) begin
				delay = int'(lfsr_take(ack_lfsr, 3));
				repeat (delay) @(negedge eth_clk);
				eth_tx_ack = 1'b1;
				got_tx.push_back(eth_tx_data);
				n = 1;
				@(negedge eth_clk);
				eth_tx_ack = 1'b0;
				while (eth_tx_data_en === 1'b1) begin
					got_tx.push_back(eth_tx_data);
					n++;
					@(negedge eth_clk);
				end
				got_len.push_back(n);
			end
		end
	end

	// User byte source answers a read one cycle later
	initial begin : source_model
		logic rden_seen;
		octet_t b;
		udp_tx = 8'h00;
		rden_seen = 1'b0;
		forever begin
			@(negedge eth_clk);
			if (rden_seen) begin
				b = lfsr_take(src_lfsr, 8);
				udp_tx = b;
				src_bytes.push_back(b);
			end
			rden_seen = (udp_tx_rden === 1'b1);
			if (rden_seen)
				rden_count++;
		end
	end

	always @(negedge eth_clk) begin
		if (udp_rx_dv === 1'b1)
			rx_got.push_back(udp_rx);
	end

	initial begin : watchdog
		#(NUM_ROWS * 1600 * 10 * 100);
		$display("timeout: the test did not finish in the expected time");
		$display("sim failed");
		$fatal(1);
	end

	initial begin : stimulus
		row_t row;
		arp_peer_t peer;
		int r;
		int i;
		rst = 1'b1;
		eth_rx_data = 8'h00;
		eth_rx_data_valid = 1'b0;
		eth_rx_frame_good = 1'b0;
		eth_rx_frame_bad = 1'b0;
		udp_tx_pending_data = 16'd0;
		stim_lfsr = 16'd13290;
		ack_lfsr = 16'd13290;
		src_lfsr = 16'd13290;
		rden_count = 0;
		rows[0] = '{k_arp, 16'd0, 1'b0};
		rows[1] = '{k_udp, 16'd5, 1'b0};
		rows[2] = '{k_udp, 16'd64, 1'b1};
		rows[3] = '{k_bad_port, 16'd20, 1'b0};
		rows[4] = '{k_bad_ip, 16'd20, 1'b0};
		rows[5] = '{k_not_ip, 16'd20, 1'b0};
		rows[6] = '{k_arp, 16'd30, 1'b1};
		rows[7] = '{k_udp, 16'd200, 1'b0};
		repeat (3) @(negedge eth_clk);
		rst = 1'b0;
		check_octet("eth_tx_data_en after reset", {7'd0, eth_tx_data_en}, 8'd0);
		check_octet("udp_rx_dv after reset", {7'd0, udp_rx_dv}, 8'd0);
		check_octet("udp_tx_rden after reset", {7'd0, udp_tx_rden}, 8'd0);
		for (r = 0; r < NUM_ROWS; r++) begin
			row = rows[r];
			rx_frame.delete();
			exp_rx.delete();
			rx_got.delete();
			exp_tx.delete();
			exp_kind.delete();
			got_tx.delete();
			got_len.delete();
			src_bytes.delete();
			rden_count = 0;
			peer.mac = 48'h02;
			for (i = 0; i < 5; i++)
				peer.mac = {peer.mac[39:0], lfsr_take(stim_lfsr, 8)};
			peer.ip = {24'h0A0505, lfsr_take(stim_lfsr, 8)};
			build_request(row, peer);
			if (row.kind == k_arp)
				build_reply(peer);
			if (row.send)
				build_udp_header(row.len);
			apply_frame(row);
			wait_frames(exp_kind.size());
			repeat (20) @(negedge eth_clk);
			if (row.kind == k_udp) begin
				check_count("received payload bytes", rx_got.size(), int'(row.len));
				for (i = 0; i < rx_got.size(); i++)
					check_octet($sformatf("received payload byte %0d", i), rx_got[i], exp_rx[i]);
			end else begin
				check_count("payload bytes from a dropped frame", rx_got.size(), 0);
			end
			compare_tx(row.len, peer);
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
eth_pkg.sv
eth_rx_parser.sv
arp_responder.sv
udp_tx_framer.sv
tx_arbiter.sv
ip_minimal.sv
tb_ip_minimal.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_ip_minimal -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
